// File: include/link_config.svh
// Single clock only; far domain assumed on clk_i, depth must stay a power of two (2 slots here)
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// ************************************************************************
// Memory link widths
// ************************************************************************

// Request address bits
`define LINK_ADDR_W 16

// Read and write data bits
`define LINK_DATA_W 32

// ************************************************************************
// Crossing geometry
// ************************************************************************

// log2 of FIFO slots per crossing
`define LINK_LOG_DEPTH 1

// Flops per pointer synchronizer, at least 2
`define LINK_SYNC_STAGES 2

`endif

// File: source/link_pkg.sv
// Request word packs opcode in the MSB, then address, then write data; no bursts or IDs
`include "link_config.svh"

package link_pkg;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_e;

  // Response code, AXI encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    req_op_e                 op;
    logic [`LINK_ADDR_W-1:0] addr;
    logic [`LINK_DATA_W-1:0] wdata;
  } req_t;

  typedef struct packed {
    resp_e                   code;
    logic [`LINK_DATA_W-1:0] rdata;
  } resp_t;

  // 1 + 16 + 32 and 2 + 32
  localparam int unsigned REQ_W  = $bits(req_t);
  localparam int unsigned RESP_W = $bits(resp_t);

endpackage

// File: source/cdc_pkg.sv
// Pointers carry one wrap bit above the slot index; Gray codes are only valid for such pointers
`include "link_config.svh"

package cdc_pkg;

  localparam int unsigned PTR_W = `LINK_LOG_DEPTH + 1;
  localparam int unsigned DEPTH = 1 << `LINK_LOG_DEPTH;

  // Slot index in the low bits, wrap flag on top
  typedef logic [PTR_W-1:0] ptr_t;

  // ************************************************************************
  // Gray conversion
  // ************************************************************************

  function automatic ptr_t bin_to_gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray_to_bin(ptr_t gray);
    ptr_t bin;
    bin[PTR_W-1] = gray[PTR_W-1];
    // Each binary bit folds in all Gray bits above it
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: source/cdc_src_fifo.sv
// Writer half only; a strobe while full is lost, and slots hold no reset value until written
`timescale 1ns/10ps
`include "link_config.svh"

module cdc_src_fifo (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      wr_strobe_i,
  input  logic [link_pkg::REQ_W-1:0]                wr_data_i,
  output logic                                      full_o,
  output cdc_pkg::ptr_t                             wptr_o,
  output logic [cdc_pkg::DEPTH*link_pkg::REQ_W-1:0] data_o,
  input  cdc_pkg::ptr_t                             rptr_i
);
  import cdc_pkg::*;
  import link_pkg::*;

  ptr_t                       wptr_bin_q;
  ptr_t                       wptr_next;
  ptr_t                       rptr_sync_q [`LINK_SYNC_STAGES];
  ptr_t                       rptr_bin;
  ptr_t                       fill;
  logic                       push;
  logic [`LINK_LOG_DEPTH-1:0] wr_slot;

  // ************************************************************************
  // Read pointer synchronizer
  // ************************************************************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `LINK_SYNC_STAGES; i++) begin
        rptr_sync_q[i] <= '0;
      end
    end else begin
      rptr_sync_q[0] <= rptr_i;
      for (int i = 1; i < `LINK_SYNC_STAGES; i++) begin
        rptr_sync_q[i] <= rptr_sync_q[i-1];
      end
    end
  end

  assign rptr_bin = gray_to_bin(rptr_sync_q[`LINK_SYNC_STAGES-1]);

  // Occupancy as seen from this side, pessimistic by the sync delay
  assign fill   = wptr_bin_q - rptr_bin;
  assign full_o = (fill == ptr_t'(DEPTH));

  // ************************************************************************
  // Write side
  // ************************************************************************

  assign push      = wr_strobe_i & ~full_o;
  assign wptr_next = wptr_bin_q + ptr_t'(1);
  assign wr_slot   = wptr_bin_q[`LINK_LOG_DEPTH-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_bin_q <= '0;
      wptr_o     <= '0;
    end else if (push) begin
      wptr_bin_q <= wptr_next;
      wptr_o     <= bin_to_gray(wptr_next);
    end
  end

  // Slot is written on the same edge the pointer moves
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_o[wr_slot*REQ_W +: REQ_W] <= wr_data_i;
    end
  end

  // A dropped strobe must leave the published pointer alone
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (wr_strobe_i && full_o) |=> $stable(wptr_o)
  );

  // Far side never reports reading past what was written
  a_fill_bounded: assert property (
    @(posedge clk_i) disable iff (rst_i)
    fill <= ptr_t'(DEPTH)
  );

endmodule

// File: source/cdc_dst_fifo.sv
// Reader half only; always pops when data is visible, so the consumer cannot stall it
`timescale 1ns/10ps
`include "link_config.svh"

module cdc_dst_fifo (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  cdc_pkg::ptr_t                              wptr_i,
  input  logic [cdc_pkg::DEPTH*link_pkg::RESP_W-1:0] data_i,
  output cdc_pkg::ptr_t                              rptr_o,
  output logic                                       rd_strobe_o,
  output logic [link_pkg::RESP_W-1:0]                rd_data_o
);
  import cdc_pkg::*;
  import link_pkg::*;

  ptr_t                       wptr_sync_q [`LINK_SYNC_STAGES];
  ptr_t                       wptr_sync;
  ptr_t                       rptr_bin_q;
  ptr_t                       rptr_next;
  logic                       pop;
  logic [`LINK_LOG_DEPTH-1:0] rd_slot;

  // Write pointer synchronizer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `LINK_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= '0;
      end
    end else begin
      wptr_sync_q[0] <= wptr_i;
      for (int i = 1; i < `LINK_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= wptr_sync_q[i-1];
      end
    end
  end

  assign wptr_sync = wptr_sync_q[`LINK_SYNC_STAGES-1];

  // Gray pointers compare directly, no conversion needed for empty
  assign pop       = (wptr_sync != rptr_o);
  assign rptr_next = rptr_bin_q + ptr_t'(1);
  assign rd_slot   = rptr_bin_q[`LINK_LOG_DEPTH-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rptr_bin_q  <= '0;
      rptr_o      <= '0;
      rd_strobe_o <= 1'b0;
    end else begin
      rd_strobe_o <= pop;
      if (pop) begin
        rptr_bin_q <= rptr_next;
        rptr_o     <= bin_to_gray(rptr_next);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      rd_data_o <= data_i[rd_slot*RESP_W +: RESP_W];
    end
  end

  // Writer on the far side must step its Gray pointer one bit at a time
  a_gray_step: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $countones(wptr_sync ^ $past(wptr_sync)) <= 1
  );

endmodule

// File: source/link_port.sv
// One master port; requests dropped while full are only flagged, never retried
`timescale 1ns/10ps
`include "link_config.svh"

module link_port (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       req_strobe_i,
  input  link_pkg::req_op_e                          req_op_i,
  input  logic [`LINK_ADDR_W-1:0]                    req_addr_i,
  input  logic [`LINK_DATA_W-1:0]                    req_wdata_i,
  output logic                                       req_drop_o,
  output cdc_pkg::ptr_t                              req_wptr_o,
  output logic [cdc_pkg::DEPTH*link_pkg::REQ_W-1:0]  req_data_o,
  input  cdc_pkg::ptr_t                              req_rptr_i,
  input  cdc_pkg::ptr_t                              resp_wptr_i,
  input  logic [cdc_pkg::DEPTH*link_pkg::RESP_W-1:0] resp_data_i,
  output cdc_pkg::ptr_t                              resp_rptr_o,
  output logic                                       resp_strobe_o,
  output link_pkg::resp_e                            resp_code_o,
  output logic [`LINK_DATA_W-1:0]                    resp_rdata_o,
  output logic [7:0]                                 err_cnt_o
);
  import link_pkg::*;

  req_t              req_word;
  resp_t             resp_word;
  logic [RESP_W-1:0] resp_raw;
  logic              req_full;
  logic              err_hit;

  // ************************************************************************
  // Request path
  // ************************************************************************

  assign req_word.op    = req_op_i;
  assign req_word.addr  = req_addr_i;
  assign req_word.wdata = req_wdata_i;

  assign req_drop_o = req_strobe_i & req_full;

  cdc_src_fifo req_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_strobe_i (req_strobe_i),
    .wr_data_i   (req_word),
    .full_o      (req_full),
    .wptr_o      (req_wptr_o),
    .data_o      (req_data_o),
    .rptr_i      (req_rptr_i)
  );

  // ************************************************************************
  // Response path
  // ************************************************************************

  cdc_dst_fifo resp_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wptr_i      (resp_wptr_i),
    .data_i      (resp_data_i),
    .rptr_o      (resp_rptr_o),
    .rd_strobe_o (resp_strobe_o),
    .rd_data_o   (resp_raw)
  );

  assign resp_word    = resp_t'(resp_raw);
  assign resp_code_o  = resp_word.code;
  assign resp_rdata_o = resp_word.rdata;

  // Saturating error count, lags the strobe by one edge
  assign err_hit = resp_strobe_o && (resp_code_o inside {RESP_SLVERR, RESP_DECERR});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_cnt_o <= '0;
    end else if (err_hit && (err_cnt_o != 8'hff)) begin
      err_cnt_o <= err_cnt_o + 8'd1;
    end
  end

  // Far side must only ever send a defined code
  a_resp_code_legal: assert property (
    @(posedge clk_i) disable iff (rst_i)
    resp_strobe_o |-> (resp_code_o inside {RESP_OKAY, RESP_EXOKAY, RESP_SLVERR, RESP_DECERR})
  );

endmodule

// File: source/link_wrap.sv
// Both ports share clk_i and rst_i; far-side pointers must belong to the matching port
`timescale 1ns/10ps
`include "link_config.svh"

module link_wrap (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  // Main port
  input  logic                                       main_req_strobe_i,
  input  link_pkg::req_op_e                          main_req_op_i,
  input  logic [`LINK_ADDR_W-1:0]                    main_req_addr_i,
  input  logic [`LINK_DATA_W-1:0]                    main_req_wdata_i,
  output logic                                       main_req_drop_o,
  output cdc_pkg::ptr_t                              main_req_wptr_o,
  output logic [cdc_pkg::DEPTH*link_pkg::REQ_W-1:0]  main_req_data_o,
  input  cdc_pkg::ptr_t                              main_req_rptr_i,
  input  cdc_pkg::ptr_t                              main_resp_wptr_i,
  input  logic [cdc_pkg::DEPTH*link_pkg::RESP_W-1:0] main_resp_data_i,
  output cdc_pkg::ptr_t                              main_resp_rptr_o,
  output logic                                       main_resp_strobe_o,
  output link_pkg::resp_e                            main_resp_code_o,
  output logic [`LINK_DATA_W-1:0]                    main_resp_rdata_o,
  output logic [7:0]                                 main_err_cnt_o,
  // CFI port
  input  logic                                       cfi_req_strobe_i,
  input  link_pkg::req_op_e                          cfi_req_op_i,
  input  logic [`LINK_ADDR_W-1:0]                    cfi_req_addr_i,
  input  logic [`LINK_DATA_W-1:0]                    cfi_req_wdata_i,
  output logic                                       cfi_req_drop_o,
  output cdc_pkg::ptr_t                              cfi_req_wptr_o,
  output logic [cdc_pkg::DEPTH*link_pkg::REQ_W-1:0]  cfi_req_data_o,
  input  cdc_pkg::ptr_t                              cfi_req_rptr_i,
  input  cdc_pkg::ptr_t                              cfi_resp_wptr_i,
  input  logic [cdc_pkg::DEPTH*link_pkg::RESP_W-1:0] cfi_resp_data_i,
  output cdc_pkg::ptr_t                              cfi_resp_rptr_o,
  output logic                                       cfi_resp_strobe_o,
  output link_pkg::resp_e                            cfi_resp_code_o,
  output logic [`LINK_DATA_W-1:0]                    cfi_resp_rdata_o,
  output logic [7:0]                                 cfi_err_cnt_o
);

  link_port main_port (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_strobe_i  (main_req_strobe_i),
    .req_op_i      (main_req_op_i),
    .req_addr_i    (main_req_addr_i),
    .req_wdata_i   (main_req_wdata_i),
    .req_drop_o    (main_req_drop_o),
    .req_wptr_o    (main_req_wptr_o),
    .req_data_o    (main_req_data_o),
    .req_rptr_i    (main_req_rptr_i),
    .resp_wptr_i   (main_resp_wptr_i),
    .resp_data_i   (main_resp_data_i),
    .resp_rptr_o   (main_resp_rptr_o),
    .resp_strobe_o (main_resp_strobe_o),
    .resp_code_o   (main_resp_code_o),
    .resp_rdata_o  (main_resp_rdata_o),
    .err_cnt_o     (main_err_cnt_o)
  );

  // Each crossing takes its own read pointer back
  link_port cfi_port (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_strobe_i  (cfi_req_strobe_i),
    .req_op_i      (cfi_req_op_i),
    .req_addr_i    (cfi_req_addr_i),
    .req_wdata_i   (cfi_req_wdata_i),
    .req_drop_o    (cfi_req_drop_o),
    .req_wptr_o    (cfi_req_wptr_o),
    .req_data_o    (cfi_req_data_o),
    .req_rptr_i    (cfi_req_rptr_i),
    .resp_wptr_i   (cfi_resp_wptr_i),
    .resp_data_i   (cfi_resp_data_i),
    .resp_rptr_o   (cfi_resp_rptr_o),
    .resp_strobe_o (cfi_resp_strobe_o),
    .resp_code_o   (cfi_resp_code_o),
    .resp_rdata_o  (cfi_resp_rdata_o),
    .err_cnt_o     (cfi_err_cnt_o)
  );

endmodule

// File: verification/far_side_model.sv
// Far domain stand-in on clk_i; answers one request per cycle unless stalled or its response FIFO is full
`timescale 1ns/10ps
`include "link_config.svh"

module far_side_model #(
  parameter logic [`LINK_DATA_W-1:0] RDATA_XOR = '0
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       stall_i,
  input  cdc_pkg::ptr_t                              req_wptr_i,
  input  logic [cdc_pkg::DEPTH*link_pkg::REQ_W-1:0]  req_data_i,
  output cdc_pkg::ptr_t                              req_rptr_o,
  output cdc_pkg::ptr_t                              resp_wptr_o,
  output logic [cdc_pkg::DEPTH*link_pkg::RESP_W-1:0] resp_data_o,
  input  cdc_pkg::ptr_t                              resp_rptr_i
);
  import cdc_pkg::*;
  import link_pkg::*;

  ptr_t  wptr_sync_q [`LINK_SYNC_STAGES];
  ptr_t  rptr_sync_q [`LINK_SYNC_STAGES];
  ptr_t  req_rd_q;
  ptr_t  resp_wr_q;
  req_t  req;
  resp_t resp;
  logic  req_pending;
  logic  resp_full;
  logic  pop;

  assign req_rptr_o  = bin_to_gray(req_rd_q);
  assign resp_wptr_o = bin_to_gray(resp_wr_q);

  assign req_pending = (wptr_sync_q[`LINK_SYNC_STAGES-1] != req_rptr_o);
  assign resp_full   = ((resp_wr_q - gray_to_bin(rptr_sync_q[`LINK_SYNC_STAGES-1]))
                        == ptr_t'(DEPTH));
  assign pop         = req_pending && !resp_full && !stall_i;

  // Memory behaviour: top address bits select the region
  always_comb begin
    req = req_t'(req_data_i[req_rd_q[`LINK_LOG_DEPTH-1:0]*REQ_W +: REQ_W]);
    case (req.addr[15:14])
      2'd3:    resp.code = RESP_DECERR;
      2'd2:    resp.code = RESP_SLVERR;
      default: resp.code = RESP_OKAY;
    endcase
    resp.rdata = '0;
    if (req.op == OP_READ) begin
      resp.rdata = 32'(req.addr) ^ RDATA_XOR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `LINK_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= '0;
        rptr_sync_q[i] <= '0;
      end
      req_rd_q  <= '0;
      resp_wr_q <= '0;
    end else begin
      wptr_sync_q[0] <= req_wptr_i;
      rptr_sync_q[0] <= resp_rptr_i;
      for (int i = 1; i < `LINK_SYNC_STAGES; i++) begin
        wptr_sync_q[i] <= wptr_sync_q[i-1];
        rptr_sync_q[i] <= rptr_sync_q[i-1];
      end
      if (pop) begin
        req_rd_q  <= req_rd_q + ptr_t'(1);
        resp_wr_q <= resp_wr_q + ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      resp_data_o[resp_wr_q[`LINK_LOG_DEPTH-1:0]*RESP_W +: RESP_W] <= resp;
    end
  end

endmodule

// File: verification/link_wrap_tb.sv
// Far domain runs on clk_i; random traffic repeats from a fixed seed, index 0 is main and 1 is CFI
`timescale 1ns/10ps
`include "link_config.svh"

module link_wrap_tb;
  import link_pkg::*;
  import cdc_pkg::*;

  localparam int RANDOM_CYCLES = 600;
  localparam int BURST_LEN     = 6;
  localparam int PLANNED_REQS  = 2 * (RANDOM_CYCLES / 4) + 2 * BURST_LEN;
  localparam int TIMEOUT_NS    = PLANNED_REQS * 200 + 2000;
  localparam logic [`LINK_DATA_W-1:0] CFI_XOR = 32'h5A5A_0000;

  logic                    clk_i;
  logic                    rst_i;
  logic                    stall       [2];
  logic                    req_strobe  [2];
  req_op_e                 req_op      [2];
  logic [`LINK_ADDR_W-1:0] req_addr    [2];
  logic [`LINK_DATA_W-1:0] req_wdata   [2];
  logic                    req_drop    [2];
  ptr_t                    req_wptr    [2];
  logic [DEPTH*REQ_W-1:0]  req_data    [2];
  ptr_t                    req_rptr    [2];
  ptr_t                    resp_wptr   [2];
  logic [DEPTH*RESP_W-1:0] resp_data   [2];
  ptr_t                    resp_rptr   [2];
  logic                    resp_strobe [2];
  resp_e                   resp_code   [2];
  logic [`LINK_DATA_W-1:0] resp_rdata  [2];
  logic [7:0]              err_cnt     [2];

  // Reference queue entries are {op, code, rdata}
  logic [`LINK_DATA_W+2:0] exp_q [2][$];
  int                      err_exp  [2];
  int                      drop_cnt [2];
  int                      resp_cnt [2];
  int                      n_checks;
  int                      n_errors;

  // Last accepted request word and the slot it must land in
  logic [REQ_W-1:0]        slot_exp  [2];
  int                      slot_idx  [2];
  logic                    slot_pend [2];
  int                      acc_cnt   [2];

  link_wrap link_wrap_i (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .main_req_strobe_i  (req_strobe[0]),
    .main_req_op_i      (req_op[0]),
    .main_req_addr_i    (req_addr[0]),
    .main_req_wdata_i   (req_wdata[0]),
    .main_req_drop_o    (req_drop[0]),
    .main_req_wptr_o    (req_wptr[0]),
    .main_req_data_o    (req_data[0]),
    .main_req_rptr_i    (req_rptr[0]),
    .main_resp_wptr_i   (resp_wptr[0]),
    .main_resp_data_i   (resp_data[0]),
    .main_resp_rptr_o   (resp_rptr[0]),
    .main_resp_strobe_o (resp_strobe[0]),
    .main_resp_code_o   (resp_code[0]),
    .main_resp_rdata_o  (resp_rdata[0]),
    .main_err_cnt_o     (err_cnt[0]),
    .cfi_req_strobe_i   (req_strobe[1]),
    .cfi_req_op_i       (req_op[1]),
    .cfi_req_addr_i     (req_addr[1]),
    .cfi_req_wdata_i    (req_wdata[1]),
    .cfi_req_drop_o     (req_drop[1]),
    .cfi_req_wptr_o     (req_wptr[1]),
    .cfi_req_data_o     (req_data[1]),
    .cfi_req_rptr_i     (req_rptr[1]),
    .cfi_resp_wptr_i    (resp_wptr[1]),
    .cfi_resp_data_i    (resp_data[1]),
    .cfi_resp_rptr_o    (resp_rptr[1]),
    .cfi_resp_strobe_o  (resp_strobe[1]),
    .cfi_resp_code_o    (resp_code[1]),
    .cfi_resp_rdata_o   (resp_rdata[1]),
    .cfi_err_cnt_o      (err_cnt[1])
  );

  far_side_model #(.RDATA_XOR(32'h0)) main_far (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall[0]),
    .req_wptr_i  (req_wptr[0]),
    .req_data_i  (req_data[0]),
    .req_rptr_o  (req_rptr[0]),
    .resp_wptr_o (resp_wptr[0]),
    .resp_data_o (resp_data[0]),
    .resp_rptr_i (resp_rptr[0])
  );

  far_side_model #(.RDATA_XOR(CFI_XOR)) cfi_far (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall[1]),
    .req_wptr_i  (req_wptr[1]),
    .req_data_i  (req_data[1]),
    .req_rptr_o  (req_rptr[1]),
    .resp_wptr_o (resp_wptr[1]),
    .resp_data_o (resp_data[1]),
    .resp_rptr_i (resp_rptr[1])
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: responses still outstanding after %0d ns", TIMEOUT_NS);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ************************************************************************
  // Reference model and checks
  // ************************************************************************

  function automatic string port_name(int p);
    return (p == 0) ? "main" : "cfi";
  endfunction

  // Region from address bits 15:14, reads echo the address
  function automatic logic [`LINK_DATA_W+2:0] expected_resp(int p, req_op_e op,
                                                           logic [`LINK_ADDR_W-1:0] addr);
    resp_e                   code;
    logic [`LINK_DATA_W-1:0] data;
    case (addr[15:14])
      2'd3:    code = RESP_DECERR;
      2'd2:    code = RESP_SLVERR;
      default: code = RESP_OKAY;
    endcase
    data = '0;
    if (op == OP_READ) begin
      data = {16'h0, addr} ^ ((p == 1) ? CFI_XOR : 32'h0);
    end
    return {op, code, data};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic observe_port(int p);
    logic [`LINK_DATA_W+2:0] expected;
    string                   test_name;
    // Slot holds the whole request one edge after acceptance
    if (slot_pend[p]) begin
      slot_pend[p] = 1'b0;
      check_value({port_name(p), " request slot"}, 64'(slot_exp[p]),
                  64'(req_data[p][slot_idx[p]*REQ_W +: REQ_W]));
    end
    if (req_drop[p]) begin
      drop_cnt[p]++;
    end
    if (req_strobe[p] && !req_drop[p]) begin
      exp_q[p].push_back(expected_resp(p, req_op[p], req_addr[p]));
      slot_exp[p]  = {req_op[p], req_addr[p], req_wdata[p]};
      slot_idx[p]  = acc_cnt[p] % DEPTH;
      slot_pend[p] = 1'b1;
      acc_cnt[p]++;
    end
    if (resp_strobe[p]) begin
      resp_cnt[p]++;
      if (exp_q[p].size() == 0) begin
        n_errors++;
        $display("Response on the %s port with no request outstanding", port_name(p));
      end else begin
        expected  = exp_q[p].pop_front();
        test_name = {port_name(p), " read response"};
        if (expected[`LINK_DATA_W+2]) begin
          test_name = {port_name(p), " write response"};
        end
        // SLVERR and DECERR share the upper code bit
        if (expected[`LINK_DATA_W+1] && (err_exp[p] < 255)) begin
          err_exp[p]++;
        end
        check_value(test_name, 64'(expected[`LINK_DATA_W+1:0]),
                    64'({resp_code[p], resp_rdata[p]}));
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      observe_port(0);
      observe_port(1);
    end
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  task automatic idle_port(int p);
    req_strobe[p] = 1'b0;
    req_op[p]     = OP_READ;
    req_addr[p]   = '0;
    req_wdata[p]  = '0;
  endtask

  task automatic random_req(int p);
    logic is_write;
    is_write      = 1'($urandom);
    req_strobe[p] = (($urandom % 4) == 0);
    req_op[p]     = is_write ? OP_WRITE : OP_READ;
    req_addr[p]   = 16'($urandom);
    req_wdata[p]  = $urandom;
  endtask

  task automatic wait_drained();
    while ((exp_q[0].size() != 0) || (exp_q[1].size() != 0)) begin
      @(posedge clk_i);
    end
    // Returned read pointers still have to cross the synchronizers
    repeat (`LINK_SYNC_STAGES + 2) @(posedge clk_i);
  endtask

  // Far side held from empty, so only two requests fit
  task automatic overflow_burst(int p);
    int drops_before;
    int resps_before;
    #1;
    stall[p]     = 1'b1;
    drops_before = drop_cnt[p];
    resps_before = resp_cnt[p];
    for (int i = 0; i < BURST_LEN; i++) begin
      @(posedge clk_i);
      #1;
      random_req(p);
      req_strobe[p] = 1'b1;
    end
    @(posedge clk_i);
    #1;
    idle_port(p);
    stall[p] = 1'b0;
    wait_drained();
    check_value({port_name(p), " overflow drops"}, 64'(BURST_LEN - 2),
                64'(drop_cnt[p] - drops_before));
    check_value({port_name(p), " overflow responses"}, 64'(2),
                64'(resp_cnt[p] - resps_before));
  endtask

  initial begin
    void'($urandom(32'hb979));
    n_checks = 0;
    n_errors = 0;
    rst_i    = 1'b1;
    for (int p = 0; p < 2; p++) begin
      stall[p]     = 1'b0;
      err_exp[p]   = 0;
      drop_cnt[p]  = 0;
      resp_cnt[p]  = 0;
      slot_exp[p]  = '0;
      slot_idx[p]  = 0;
      slot_pend[p] = 1'b0;
      acc_cnt[p]   = 0;
      idle_port(p);
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Quiet state before any request
    @(negedge clk_i);
    for (int p = 0; p < 2; p++) begin
      check_value({port_name(p), " reset strobes"}, 64'(0), 64'({resp_strobe[p], req_drop[p]}));
      check_value({port_name(p), " reset error count"}, 64'(0), 64'(err_cnt[p]));
      check_value({port_name(p), " reset pointers"}, 64'(0), 64'({req_wptr[p], resp_rptr[p]}));
    end

    // Both ports busy at once, with short far-side stalls
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      @(posedge clk_i);
      #1;
      for (int p = 0; p < 2; p++) begin
        random_req(p);
        stall[p] = (($urandom % 8) == 0);
      end
    end
    @(posedge clk_i);
    #1;
    for (int p = 0; p < 2; p++) begin
      idle_port(p);
      stall[p] = 1'b0;
    end
    wait_drained();

    overflow_burst(0);
    overflow_burst(1);

    for (int p = 0; p < 2; p++) begin
      check_value({port_name(p), " error count"}, 64'(err_exp[p]), 64'(err_cnt[p]));
    end

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
source/link_pkg.sv
source/cdc_pkg.sv
source/cdc_src_fifo.sv
source/cdc_dst_fifo.sv
source/link_port.sv
source/link_wrap.sv
verification/far_side_model.sv
verification/link_wrap_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the link wrapper testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module link_wrap_tb \
  -Mdir "$BUILD_DIR" -o link_wrap_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/link_wrap_sim" | tee "$LOG"
sim_status=${PIPESTATUS[0]}
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
exit 0
